// File: src/alu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants of the arithmetic coprocessor: opcodes,
// the host register map, STATUS field positions, command/result words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package alu_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        OP_SHL = 3'd0,               // a << b[4:0]
        OP_SRL = 3'd1,               // logical right
        OP_SRA = 3'd2,               // arithmetic right
        OP_MUL = 3'd3,               // 64-bit unsigned product
        OP_DIV = 3'd4                // quotient and remainder, 5..7 illegal
    } alu_op_t;

    typedef struct packed {
        alu_op_t op;
        word_t   a;
        word_t   b;
    } alu_cmd_t;                     // 67 bits

    typedef struct packed {
        word_t lo;                   // shift / low product / quotient
        word_t hi;                   // zero / high product / remainder
        logic  dbz;                  // divide by zero
    } alu_res_t;                     // 65 bits

    typedef logic [2:0] reg_addr_t;  // word address

    localparam reg_addr_t REG_OPA    = 3'd0;  // rw
    localparam reg_addr_t REG_OPB    = 3'd1;  // rw
    localparam reg_addr_t REG_CMD    = 3'd2;  // wo, pushes a command
    localparam reg_addr_t REG_STATUS = 3'd3;  // ro
    localparam reg_addr_t REG_RES_LO = 3'd4;  // ro
    localparam reg_addr_t REG_RES_HI = 3'd5;  // ro, read pops the result

    localparam int ST_FULL_BIT = 0;  // command queue full
    localparam int ST_DBZ_BIT  = 1;  // dbz of head result
    localparam int ST_CNT_LSB  = 8;  // results waiting, bits 15..8
    localparam int ST_CNT_W    = 8;

endpackage

// File: src/sync_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous queue for any packed payload. Head is shown on pop_data,
// a pop removes it; a push lands at pop_data one cycle later when empty
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  payload_t                     push_data,
    output logic                         full,
    input  logic                         pop,
    output payload_t                     pop_data,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];      // storage, no reset
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign do_push  = push && !full;  // push while full is ignored
    assign do_pop   = pop && !empty;
    assign full     = (count == CW'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];    // head of queue

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
            if (do_pop)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // both or neither
            endcase
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("push into full queue");
    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
        else $error("pop from empty queue");

endmodule

// File: src/wb_alu_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave of the coprocessor. Holds the operands, turns
// a REG_CMD write into a queued command, returns and pops results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module wb_alu_port #(
    parameter int CNT_W = 3              // width of res_count
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  alu_pkg::reg_addr_t adr,
    input  alu_pkg::word_t     dat_w,
    output alu_pkg::word_t     dat_r,
    output logic               ack,
    output logic               cmd_push,
    output alu_pkg::alu_cmd_t  cmd_data,
    input  logic               cmd_full,
    output logic               res_pop,
    input  alu_pkg::alu_res_t  res_data,
    input  logic               res_empty,
    input  logic [CNT_W-1:0]   res_count
);
    import alu_pkg::*;

    word_t opa;                          // operand a
    word_t opb;                          // operand b
    word_t status;
    word_t rd_val;                       // read mux
    logic  req;
    logic  cmd_wr;
    logic  hold;
    logic  op_legal;

    assign req      = cyc && stb && !ack;         // new access outside the ack cycle
    assign cmd_wr   = req && we && (adr == REG_CMD);
    assign hold     = cmd_wr && cmd_full;         // ack withheld as back-pressure
    assign op_legal = (dat_w[2:0] <= 3'(OP_DIV));
    assign cmd_push = cmd_wr && !cmd_full && op_legal;  // illegal codes dropped
    assign cmd_data = '{op: alu_op_t'(dat_w[2:0]), a: opa, b: opb};
    assign res_pop  = req && !we && (adr == REG_RES_HI) && !res_empty;

    always_comb begin
        status                          = '0;
        status[ST_FULL_BIT]             = cmd_full;
        status[ST_DBZ_BIT]              = !res_empty && res_data.dbz;
        status[ST_CNT_LSB +: ST_CNT_W]  = ST_CNT_W'(res_count);
    end

    always_comb begin
        case (adr)
            REG_OPA:    rd_val = opa;
            REG_OPB:    rd_val = opb;
            REG_STATUS: rd_val = status;
            REG_RES_LO: rd_val = res_empty ? '0 : res_data.lo;  // zero when none waits
            REG_RES_HI: rd_val = res_empty ? '0 : res_data.hi;
            default:    rd_val = '0;                            // cmd is write only
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            opa <= '0;
            opb <= '0;
        end else begin
            ack <= req && !hold;         // one-cycle registered pulse
            if (req && we) begin
                case (adr)
                    REG_OPA: opa <= dat_w;
                    REG_OPB: opb <= dat_w;
                    default: ;           // cmd pushed and the rest read only
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !we) dat_r <= rd_val;  // valid with ack
    end

    ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
        ack |-> (cyc && stb))
        else $error("ack without a bus request");

endmodule

// File: src/radix2_divider.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Restoring unsigned divider, one quotient bit per cycle. Pulse start
// with x and y, busy holds for 32 cycles, then q, r and dbz are valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module radix2_divider (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  alu_pkg::word_t x,        // dividend
    input  alu_pkg::word_t y,        // divisor
    output logic           busy,
    output logic           dbz,
    output alu_pkg::word_t q,        // quotient
    output alu_pkg::word_t r         // remainder
);
    import alu_pkg::*;

    localparam int W = $bits(word_t);

    logic [W:0]   acc;               // partial remainder, one bit wider
    logic [W:0]   diff;
    logic [W-1:0] rem_n;
    logic [W-1:0] qsh;               // dividend bits out, quotient bits in
    word_t        ydiv;              // latched divisor
    logic [4:0]   cnt;               // 31 down to 0
    logic         ge;

    assign diff  = acc - {1'b0, ydiv};
    assign ge    = (acc >= {1'b0, ydiv});   // always true for y == 0
    assign rem_n = ge ? diff[W-1:0] : acc[W-1:0];  // restore on borrow
    assign q     = qsh;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            dbz  <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            dbz  <= (y == '0);           // flag taken at start
            cnt  <= 5'd31;
        end else if (busy) begin
            cnt <= cnt - 5'd1;
            if (cnt == 5'd0) busy <= 1'b0;  // last bit done
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc  <= {{W{1'b0}}, x[W-1]};    // first dividend bit
            qsh  <= {x[W-2:0], 1'b0};
            ydiv <= y;
        end else if (busy) begin
            acc <= {rem_n, qsh[W-1]};       // shift in next dividend bit
            qsh <= {qsh[W-2:0], ge};
            if (cnt == 5'd0) r <= rem_n;    // final remainder
        end
    end

endmodule

// File: src/alu_exec.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute unit. Pops one command at a time, does shifts and the product
// in one cycle, runs divisions on the iterative divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module alu_exec (
    input  logic              clk,
    input  logic              rst,
    output logic              cmd_pop,
    input  alu_pkg::alu_cmd_t cmd_data,
    input  logic              cmd_empty,
    output logic              res_push,
    output alu_pkg::alu_res_t res_data,
    input  logic              res_full
);
    import alu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,                     // waiting for a command
        ST_DIV,                      // divider running
        ST_HOLD                      // result ready, pushing
    } state_t;

    state_t      state;
    alu_res_t    res_q;              // finished result
    logic [63:0] prod;
    logic [4:0]  amt;                // shift amount
    logic        div_start;
    logic        div_busy;
    logic        div_dbz;
    word_t       div_q;
    word_t       div_r;

    assign cmd_pop   = (state == ST_IDLE) && !cmd_empty;
    assign div_start = cmd_pop && (cmd_data.op == OP_DIV);
    assign res_push  = (state == ST_HOLD) && !res_full;  // held while queue full
    assign res_data  = res_q;
    assign amt       = cmd_data.b[4:0];
    assign prod      = 64'(cmd_data.a) * 64'(cmd_data.b);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (cmd_pop) state <= div_start ? ST_DIV : ST_HOLD;
                ST_DIV:  if (!div_busy) state <= ST_HOLD;  // busy set the cycle after start
                ST_HOLD: if (res_push) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            case (cmd_data.op)
                OP_SHL:  res_q <= '{lo: cmd_data.a << amt, hi: '0, dbz: 1'b0};
                OP_SRL:  res_q <= '{lo: cmd_data.a >> amt, hi: '0, dbz: 1'b0};
                OP_SRA:  res_q <= '{lo: word_t'($signed(cmd_data.a) >>> amt), hi: '0, dbz: 1'b0};
                OP_MUL:  res_q <= '{lo: prod[31:0], hi: prod[63:32], dbz: 1'b0};
                default: res_q <= res_q;     // division fills in later
            endcase
        end else if (state == ST_DIV && !div_busy) begin
            res_q <= '{lo: div_q, hi: div_r, dbz: div_dbz};
        end
    end

    radix2_divider radix2_divider_inst (
        .clk   (clk),
        .rst   (rst),
        .start (div_start),
        .x     (cmd_data.a),
        .y     (cmd_data.b),
        .busy  (div_busy),
        .dbz   (div_dbz),
        .q     (div_q),
        .r     (div_r)
    );

    no_start_while_busy: assert property (@(posedge clk) disable iff (rst)
        div_start |-> !div_busy)
        else $error("divider started while busy");

endmodule

// File: src/alu_coproc_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coprocessor top: Wishbone port, command queue, execute unit and
// result queue. Queue depths are set here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module alu_coproc_top #(
    parameter int CMD_DEPTH = 4,
    parameter int RES_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  alu_pkg::reg_addr_t adr,
    input  alu_pkg::word_t     dat_w,
    output alu_pkg::word_t     dat_r,
    output logic               ack
);
    import alu_pkg::*;

    localparam int RES_CW = $clog2(RES_DEPTH + 1);

    logic              cmd_push, cmd_full, cmd_pop, cmd_empty;
    alu_cmd_t          cmd_in, cmd_head;  // into queue / head to exec
    logic              res_push, res_full, res_pop, res_empty;
    alu_res_t          res_in, res_head;
    logic [RES_CW-1:0] res_count;         // shown in STATUS

    wb_alu_port #(.CNT_W(RES_CW)) wb_alu_port_inst (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .cmd_push(cmd_push), .cmd_data(cmd_in), .cmd_full(cmd_full),
        .res_pop(res_pop), .res_data(res_head), .res_empty(res_empty),
        .res_count(res_count)
    );

    sync_fifo #(.payload_t(alu_cmd_t), .DEPTH(CMD_DEPTH)) cmd_fifo_inst (
        .clk(clk), .rst(rst), .push(cmd_push), .push_data(cmd_in), .full(cmd_full),
        .pop(cmd_pop), .pop_data(cmd_head), .empty(cmd_empty), .count()
    );

    alu_exec alu_exec_inst (
        .clk(clk), .rst(rst), .cmd_pop(cmd_pop), .cmd_data(cmd_head),
        .cmd_empty(cmd_empty), .res_push(res_push), .res_data(res_in),
        .res_full(res_full)
    );

    sync_fifo #(.payload_t(alu_res_t), .DEPTH(RES_DEPTH)) res_fifo_inst (
        .clk(clk), .rst(rst), .push(res_push), .push_data(res_in), .full(res_full),
        .pop(res_pop), .pop_data(res_head), .empty(res_empty), .count(res_count)
    );

endmodule

// File: include/tb_alu_bus.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone host tasks and typed compare tasks of the coprocessor
// testbench; included inside the testbench module after its signals
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_ALU_BUS_SVH
`define TB_ALU_BUS_SVH

// one classic cycle, read data comes back with ack
task automatic bus_access(input logic write, input reg_addr_t a, input word_t d,
                          output word_t rd);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    adr   <= a;
    dat_w <= d;
    @(negedge clk);                      // sample away from the edge
    while (!ack) @(negedge clk);         // held command writes wait here
    rd = dat_r;
    @(posedge clk);
    cyc <= 1'b0;                         // drop in the cycle after ack
    stb <= 1'b0;
    we  <= 1'b0;
endtask

task automatic wb_write(input reg_addr_t a, input word_t d);
    word_t discard;
    bus_access(1'b1, a, d, discard);
endtask

task automatic wb_read(input reg_addr_t a, output word_t d);
    bus_access(1'b0, a, '0, d);
endtask

task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp)
        abort_run($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                            $time, what, got, exp));
endtask

task automatic check_res(input alu_res_t got, input alu_res_t exp);
    if (got !== exp)
        abort_run($sformatf("CHECK FAILED at %0t ns: result lo %h hi %h dbz %b, expected %h %h %b",
                            $time, got.lo, got.hi, got.dbz, exp.lo, exp.hi, exp.dbz));
endtask

// whole word compared, so reserved bits must read zero
task automatic check_status(input word_t got, input logic full, input logic dbz,
                            input int unsigned cnt);
    word_t exp;
    exp                         = '0;
    exp[ST_FULL_BIT]            = full;
    exp[ST_DBZ_BIT]             = dbz;
    exp[ST_CNT_LSB +: ST_CNT_W] = ST_CNT_W'(cnt);
    check_word("STATUS", got, exp);
endtask

`endif

// File: dv/tb_alu_coproc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the arithmetic coprocessor. Random commands over Wishbone,
// results checked against a model, order and back-pressure exercised
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_alu_coproc;
    import alu_pkg::*;

    localparam int CMD_DEPTH      = 4;
    localparam int RES_DEPTH      = 4;
    localparam int TIMEOUT_CYCLES = 300 * 60;  // commands times cycles each

    logic      clk;
    logic      rst;
    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    word_t     dat_w;
    word_t     dat_r;
    logic      ack;
    int        cycles;
    int        errors;
    logic      full_seen;                      // cmd full bit observed
    alu_res_t  exp_q[$];                       // expected results, oldest first

    task automatic abort_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    `include "tb_alu_bus.svh"

    alu_coproc_top #(.CMD_DEPTH(CMD_DEPTH), .RES_DEPTH(RES_DEPTH)) alu_coproc_top_inst (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                 // 10 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            abort_run($sformatf("simulation timed out after %0d cycles", cycles));
    end

    // expected result from the operation rules
    function automatic alu_res_t model_result(alu_op_t op, word_t a, word_t b);
        alu_res_t    r;
        logic [63:0] p;
        int          s;
        r = '0;
        s = int'(b[4:0]);                      // shift amount, low five bits
        p = {32'd0, a} * {32'd0, b};
        case (op)
            OP_SHL:  r.lo = a << s;
            OP_SRL:  r.lo = a >> s;
            OP_SRA:  r.lo = (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : '0);  // sign fill
            OP_MUL:  {r.hi, r.lo} = p;
            default: begin
                if (b == '0) begin
                    r.lo  = '1;                // all ones, remainder is dividend
                    r.hi  = a;
                    r.dbz = 1'b1;
                end else begin
                    r.lo = a / b;
                    r.hi = a % b;
                end
            end
        endcase
        return r;
    endfunction

    task automatic send_cmd(input alu_op_t op, input word_t a, input word_t b);
        wb_write(REG_OPA, a);
        wb_write(REG_OPB, b);
        wb_write(REG_CMD, word_t'(op));        // may be held while queue full
        exp_q.push_back(model_result(op, a, b));
    endtask

    task automatic read_status(output word_t st);
        wb_read(REG_STATUS, st);
        if (st[ST_FULL_BIT]) full_seen = 1'b1;
        if (int'(st[ST_CNT_LSB +: ST_CNT_W]) > RES_DEPTH)
            abort_run($sformatf("CHECK FAILED at %0t ns: result count %0d above depth %0d",
                                $time, st[ST_CNT_LSB +: ST_CNT_W], RES_DEPTH));
    endtask

    // wait for a result, then read lo and hi (the hi read pops it)
    task automatic get_result(input logic alone);
        word_t    st;
        word_t    lo;
        word_t    hi;
        alu_res_t exp;
        alu_res_t got;
        exp = exp_q.pop_front();
        read_status(st);
        while (st[ST_CNT_LSB +: ST_CNT_W] == '0) read_status(st);
        if (alone) check_status(st, 1'b0, exp.dbz, 1);  // exactly one waiting
        wb_read(REG_RES_LO, lo);
        wb_read(REG_RES_HI, hi);
        got = '{lo: lo, hi: hi, dbz: st[ST_DBZ_BIT]};
        check_res(got, exp);
    endtask

    initial begin
        word_t   st;
        word_t   rd;
        word_t   a;
        alu_op_t op;
        void'($urandom(61542));
        rst       = 1'b1;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        cycles    = 0;
        errors    = 0;
        full_seen = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        read_status(st);
        check_status(st, 1'b0, 1'b0, 0);       // empty after reset
        wb_read(REG_RES_LO, rd);
        check_word("result lo with none waiting", rd, '0);
        wb_read(REG_RES_HI, rd);
        check_word("result hi with none waiting", rd, '0);
        read_status(st);
        check_status(st, 1'b0, 1'b0, 0);       // nothing popped
        for (int i = 0; i < 60; i++) begin     // all three shifts
            send_cmd(alu_op_t'($urandom % 3), $urandom, $urandom);
            get_result(1'b1);
        end
        for (int i = 0; i < 40; i++) begin
            send_cmd(OP_MUL, $urandom, $urandom);
            get_result(1'b1);
        end
        for (int i = 0; i < 48; i++) begin     // last eight by zero
            send_cmd(OP_DIV, $urandom, (i < 40) ? ($urandom >> ($urandom % 32)) : '0);
            get_result(1'b1);
        end
        a = $urandom;
        wb_write(REG_OPA, a);
        wb_read(REG_OPA, rd);
        check_word("operand a readback", rd, a);
        wb_write(REG_CMD, word_t'(3'd5 + 3'($urandom % 3)));  // illegal code
        send_cmd(OP_SRL, a, $urandom);
        get_result(1'b1);                      // count of one, illegal one dropped
        for (int i = 0; i < 40; i++) begin     // bursts of eight, mostly divisions
            op = (i % 8 < 6) ? OP_DIV : alu_op_t'($urandom % 5);
            send_cmd(op, $urandom, $urandom >> ($urandom % 32));
            read_status(st);
            if (i % 8 == 7) begin
                while (exp_q.size() > 0) get_result(1'b0);
            end
        end
        if (!full_seen) abort_run("command queue full bit never showed in STATUS");
        read_status(st);
        check_status(st, 1'b0, 1'b0, 0);       // drained
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
src/alu_pkg.sv
src/sync_fifo.sv
src/wb_alu_port.sv
src/radix2_divider.sv
src/alu_exec.sv
src/alu_coproc_top.sv
dv/tb_alu_coproc.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_alu_coproc -f files.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_alu_coproc 2>&1)
echo "$out"
echo "$out" | grep -qx "Everything OK" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
